/* Bender.yml */
package:
  name: mem_subsys

sources:
  - files:
      - src/mem_pkg.sv
      - src/mem_arbiter.sv
      - src/l1i_cache.sv
      - src/l1d_cache.sv
      - src/main_mem.sv
      - src/mem_subsys_top.sv
  - target: test
    files:
      - tests/mem_subsys_tb.sv

/* mem_subsys.f */
src/mem_pkg.sv
src/mem_arbiter.sv
src/l1i_cache.sv
src/l1d_cache.sv
src/main_mem.sv
src/mem_subsys_top.sv
tests/mem_subsys_tb.sv

/* src/l1d_cache.sv */
// Direct-mapped write-through, no-write-allocate data cache with byte strobes
`timescale 1ns/100ps
`default_nettype none

module l1d_cache import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t cpu_req,
    output mem_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        WRITE
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    addr_t                  addr_q;
    strb_t                  wstrb_q;
    word_t                  wdata_q;
    tag_t                   tag_q  [CACHE_LINES];
    word_t                  data_q [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    index_t                 idx;
    tag_t                   tag;
    logic                   hit;
    logic                   is_write;

    assign idx      = addr_q[INDEX_W+OFFSET_W-1:OFFSET_W];
    assign tag      = addr_q[ADDR_W-1:INDEX_W+OFFSET_W];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign is_write = |wstrb_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (cpu_req.valid) state_d = LOOKUP;
            LOOKUP: begin
                if (is_write) begin
                    state_d = WRITE;                       // Always through to memory
                end else begin
                    state_d = hit ? IDLE : FILL;
                end
            end
            FILL:    if (mem_rsp.ready) state_d = IDLE;
            WRITE:   if (mem_rsp.ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign cpu_rsp.ready = ((state_q == LOOKUP) && !is_write && hit) ||
                           (((state_q == FILL) || (state_q == WRITE)) && mem_rsp.ready);
    assign cpu_rsp.rdata = (state_q == LOOKUP) ? data_q[idx] : mem_rsp.rdata;

    assign mem_req.valid = (state_q == FILL) || (state_q == WRITE);
    assign mem_req.wstrb = (state_q == WRITE) ? wstrb_q : '0;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = wdata_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == FILL) && mem_rsp.ready) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && cpu_req.valid) begin
            addr_q  <= cpu_req.addr;
            wstrb_q <= cpu_req.wstrb;
            wdata_q <= cpu_req.wdata;
        end
        if ((state_q == FILL) && mem_rsp.ready) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rsp.rdata;
        end
        // Write hit merges the same bytes as memory, a miss leaves the line alone
        if ((state_q == WRITE) && mem_rsp.ready && hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb_q[b]) begin
                    data_q[idx][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/l1i_cache.sv */
// Direct-mapped read-only instruction cache with single-word miss fill
`timescale 1ns/100ps
`default_nettype none

module l1i_cache import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t cpu_req,
    output mem_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    addr_t                  addr_q;
    tag_t                   tag_q  [CACHE_LINES];
    word_t                  data_q [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    index_t                 idx;
    tag_t                   tag;
    logic                   hit;

    assign idx = addr_q[INDEX_W+OFFSET_W-1:OFFSET_W];
    assign tag = addr_q[ADDR_W-1:INDEX_W+OFFSET_W];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cpu_req.valid) state_d = LOOKUP;
            LOOKUP:  state_d = hit ? IDLE : FILL;
            FILL:    if (mem_rsp.ready) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign cpu_rsp.ready = ((state_q == LOOKUP) && hit) ||
                           ((state_q == FILL) && mem_rsp.ready);
    assign cpu_rsp.rdata = (state_q == FILL) ? mem_rsp.rdata : data_q[idx];

    // Fetch side never writes
    assign mem_req.valid = (state_q == FILL);
    assign mem_req.wstrb = '0;
    assign mem_req.addr  = addr_q;
    assign mem_req.wdata = '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == FILL) && mem_rsp.ready) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && cpu_req.valid) begin
            addr_q <= cpu_req.addr;                        // Held for the whole access
        end
        if ((state_q == FILL) && mem_rsp.ready) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rsp.rdata;
        end
    end

endmodule

`default_nettype wire

/* src/main_mem.sv */
// Word-wide main memory with fixed wait states and byte-strobe writes
`timescale 1ns/100ps
`default_nettype none

module main_mem import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    word_t     mem_q [MEM_WORDS];
    mem_idx_t  idx;
    wait_cnt_t cnt_q;
    logic      fire;

    // Simulation model starts from all-zero contents
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    assign idx  = mem_req.addr[MEM_AW+OFFSET_W-1:OFFSET_W];
    assign fire = mem_req.valid && (cnt_q == wait_cnt_t'(MEM_WAIT));

    assign mem_rsp.ready = fire;
    assign mem_rsp.rdata = mem_q[idx];                     // Old word on a write

    // Counts consecutive valid cycles
    always_ff @(posedge clk_i) begin
        if (rst_i || !mem_req.valid || fire) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always @(posedge clk_i) begin
        if (fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mem_req.wstrb[b]) begin
                    mem_q[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
// Memory port arbiter for timer, instruction cache and data cache
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t timer_req,
    output mem_rsp_t timer_rsp,
    input  mem_req_t instr_req,
    output mem_rsp_t instr_rsp,
    input  mem_req_t data_req,
    output mem_rsp_t data_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    grant_e   grant_q;
    logic     timer_sel;
    mem_req_t cache_req;

    assign timer_sel = timer_req.valid;                    // Timer always wins
    assign cache_req = (grant_q == GRANT_DATA) ? data_req : instr_req;

    always_comb begin
        if (timer_sel) begin
            mem_req       = timer_req;
            mem_req.wstrb = '0;                            // Timer only reads
        end else begin
            mem_req = cache_req;
        end
    end

    // Read data is shared and ready goes only to the port owner
    always_comb begin
        timer_rsp       = mem_rsp;
        instr_rsp       = mem_rsp;
        data_rsp        = mem_rsp;
        timer_rsp.ready = mem_rsp.ready & timer_sel;
        instr_rsp.ready = mem_rsp.ready & ~timer_sel & (grant_q == GRANT_INSTR);
        data_rsp.ready  = mem_rsp.ready & ~timer_sel & (grant_q == GRANT_DATA);
    end

    // Sticky grant between the two caches
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_q <= GRANT_INSTR;
        end else begin
            case ({instr_req.valid, data_req.valid})
                2'b01:   grant_q <= GRANT_DATA;
                2'b10:   grant_q <= GRANT_INSTR;
                2'b11:   grant_q <= grant_q;               // Both waiting so hold
                default: grant_q <= GRANT_INSTR;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
// Subsystem widths, cache geometry, memory timing, bus structs and grant type
`default_nettype none

package mem_pkg;

    // ========================================================================
    // Geometry
    // ========================================================================
    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;
    localparam int OFFSET_W    = $clog2(STRB_W);           // Byte offset in a word
    localparam int CACHE_LINES = 16;
    localparam int INDEX_W     = $clog2(CACHE_LINES);
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = $clog2(MEM_WORDS);          // Low word-address bits only
    localparam int MEM_WAIT  = 2;
    localparam int WAIT_W    = $clog2(MEM_WAIT + 1);

    // ========================================================================
    // Types
    // ========================================================================
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [STRB_W-1:0]  strb_t;                    // All zero is a read
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [MEM_AW-1:0]  mem_idx_t;
    typedef logic [WAIT_W-1:0]  wait_cnt_t;

    typedef struct packed {
        logic  valid;
        strb_t wstrb;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic {
        GRANT_INSTR,
        GRANT_DATA
    } grant_e;

endpackage

`default_nettype wire

/* src/mem_subsys_top.sv */
// Memory subsystem top with instruction cache, data cache, arbiter and main memory
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t cpu_i_req,
    output mem_rsp_t cpu_i_rsp,
    input  mem_req_t cpu_d_req,
    output mem_rsp_t cpu_d_rsp,
    input  mem_req_t timer_req,
    output mem_rsp_t timer_rsp
);

    mem_req_t l1i_mem_req;
    mem_rsp_t l1i_mem_rsp;
    mem_req_t l1d_mem_req;
    mem_rsp_t l1d_mem_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    l1i_cache u_l1i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cpu_req (cpu_i_req),
        .cpu_rsp (cpu_i_rsp),
        .mem_req (l1i_mem_req),
        .mem_rsp (l1i_mem_rsp)
    );

    l1d_cache u_l1d (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .cpu_req (cpu_d_req),
        .cpu_rsp (cpu_d_rsp),
        .mem_req (l1d_mem_req),
        .mem_rsp (l1d_mem_rsp)
    );

    mem_arbiter u_arbiter (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .timer_req (timer_req),
        .timer_rsp (timer_rsp),
        .instr_req (l1i_mem_req),
        .instr_rsp (l1i_mem_rsp),
        .data_req  (l1d_mem_req),
        .data_rsp  (l1d_mem_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    main_mem u_mem (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

/* tests/mem_subsys_cases.txt */
// Columns: port (1 instr, 2 data, 3 timer), group, wstrb, addr, wdata, expected rdata
// Lines with the same group start in the same cycle, rdata is checked on reads only
2 01 F 00000100 11223344 00000000
2 02 0 00000100 00000000 11223344
2 03 3 00000100 AABBCCDD 00000000
2 04 0 00000100 00000000 1122CCDD
2 05 8 00000100 99000000 00000000
2 06 0 00000100 00000000 9922CCDD
2 07 F 00000204 DEADBEEF 00000000
2 08 5 00000208 12345678 00000000
2 09 F 0000020C 0BADF00D 00000000
2 0A F 00000140 CAFEF00D 00000000
1 0B 0 00000204 00000000 DEADBEEF
1 0C 0 00000204 00000000 DEADBEEF
1 0D 0 00000208 00000000 00340078
1 0E 0 00000100 00000000 9922CCDD
2 0E 0 00000208 00000000 00340078
1 0F 0 00000204 00000000 DEADBEEF
2 0F 0 00000100 00000000 9922CCDD
2 10 0 0000020C 00000000 0BADF00D
3 10 0 00000140 00000000 CAFEF00D
2 11 0 00000140 00000000 CAFEF00D
2 12 0 00000100 00000000 9922CCDD
2 13 0 00000140 00000000 CAFEF00D
3 14 0 00000204 00000000 DEADBEEF
1 14 0 0000020C 00000000 0BADF00D
2 14 0 00000208 00000000 00340078

/* tests/mem_subsys_tb.sv */
// Testbench for the memory subsystem top, with case file stimulus and read data checks
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_tb import mem_pkg::*; ();

    localparam int FIELDS    = 6;                          // Words per case line
    localparam int MAX_CASES = 64;
    localparam int PORT_I    = 1;
    localparam int PORT_D    = 2;
    localparam int PORT_T    = 3;

    logic        clk_i;
    logic        rst_i;
    mem_req_t    cpu_i_req;
    mem_rsp_t    cpu_i_rsp;
    mem_req_t    cpu_d_req;
    mem_rsp_t    cpu_d_rsp;
    mem_req_t    timer_req;
    mem_rsp_t    timer_rsp;
    logic [31:0] case_words [FIELDS*MAX_CASES];
    int          n_cases;
    int          pass_count;
    int          fail_count;
    addr_t       fetched_addr [CACHE_LINES];               // Last fetch per I-cache line
    logic [CACHE_LINES-1:0] fetched_valid;

    mem_subsys_top DUT (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cpu_i_req (cpu_i_req),
        .cpu_i_rsp (cpu_i_rsp),
        .cpu_d_req (cpu_d_req),
        .cpu_d_rsp (cpu_d_rsp),
        .timer_req (timer_req),
        .timer_rsp (timer_rsp)
    );

    always #5 clk_i = ~clk_i;

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic mem_rsp_t port_rsp(input int port);
        case (port)
            PORT_I:  return cpu_i_rsp;
            PORT_D:  return cpu_d_rsp;
            default: return timer_rsp;
        endcase
    endfunction

    function automatic string rsp_name(input int port);
        case (port)
            PORT_I:  return "cpu_i_rsp";
            PORT_D:  return "cpu_d_rsp";
            default: return "timer_rsp";
        endcase
    endfunction

    task automatic drive_port(input int port, input mem_req_t req);
        case (port)
            PORT_I:  cpu_i_req <= req;
            PORT_D:  cpu_d_req <= req;
            default: timer_req <= req;
        endcase
    endtask

    // Runs one access and holds it until its own ready
    task automatic run_access(input int c);
        int       port;
        int       cycles;
        mem_req_t req;
        mem_rsp_t rsp;
        word_t    expected;
        index_t   line;
        logic     hit;
        port      = case_words[FIELDS*c];
        req.valid = 1'b1;
        req.wstrb = strb_t'(case_words[FIELDS*c+2]);
        req.addr  = case_words[FIELDS*c+3];
        req.wdata = case_words[FIELDS*c+4];
        expected  = case_words[FIELDS*c+5];
        line      = req.addr[INDEX_W+OFFSET_W-1:OFFSET_W];
        hit       = (port == PORT_I) && fetched_valid[line] && (fetched_addr[line] == req.addr);
        cycles    = 0;
        rsp       = '0;
        @(posedge clk_i);
        drive_port(port, req);
        while (!rsp.ready) begin
            @(negedge clk_i);                              // Outputs settled mid-cycle
            cycles++;
            rsp = port_rsp(port);
        end
        @(posedge clk_i);
        drive_port(port, '0);
        if ((port == PORT_T) || (req.wstrb == '0)) begin
            check_word({rsp_name(port), ".rdata"}, rsp.rdata, expected);
        end
        if (hit) begin
            check_word({rsp_name(port), " hit latency"}, word_t'(cycles - 1), word_t'(1));
        end
        if (port == PORT_I) begin
            fetched_valid[line] = 1'b1;
            fetched_addr[line]  = req.addr;
        end
    endtask

    task automatic launch_port(input int port, input int first, input int last);
        for (int c = first; c <= last; c++) begin
            if (case_words[FIELDS*c] == port) begin
                run_access(c);
            end
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int first;
        int last;
        int group;
        int fails_before;
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        cpu_i_req     = '0;
        cpu_d_req     = '0;
        timer_req     = '0;
        pass_count    = 0;
        fail_count    = 0;
        fetched_valid = '0;
        for (int i = 0; i < FIELDS*MAX_CASES; i++) begin
            case_words[i] = '0;                            // Port zero ends the list
        end
        $readmemh("tests/mem_subsys_cases.txt", case_words);
        n_cases = 0;
        while ((n_cases < MAX_CASES) && (case_words[FIELDS*n_cases] != 0)) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("No cases were read from the case file");
            fail_count++;
        end

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        fails_before = fail_count;
        repeat (4) begin
            @(negedge clk_i);
            check_word("cpu_i_rsp.ready", word_t'(cpu_i_rsp.ready), '0);
            check_word("cpu_d_rsp.ready", word_t'(cpu_d_rsp.ready), '0);
            check_word("timer_rsp.ready", word_t'(timer_rsp.ready), '0);
        end
        $display("Idle after reset: %s", (fail_count == fails_before) ? "ok" : "mismatch");

        first = 0;
        while (first < n_cases) begin
            group = case_words[FIELDS*first+1];
            last  = first;
            while ((last + 1 < n_cases) && (case_words[FIELDS*(last+1)+1] == group)) begin
                last++;
            end
            fails_before = fail_count;
            fork
                launch_port(PORT_I, first, last);
                launch_port(PORT_D, first, last);
                launch_port(PORT_T, first, last);
            join
            $display("Group %0d: %0d access(es), %s", group, last - first + 1,
                     (fail_count == fails_before) ? "ok" : "mismatch");
            first = last + 1;
        end

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog allows about 40 cycles per case
    initial begin
        #1;
        repeat ((n_cases + 1) * 40) @(posedge clk_i);
        $display("Timeout: the accesses did not finish within %0d cycles", (n_cases + 1) * 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
